// File: dmaController.f
+incdir+src
src/dmaPkg.sv
src/priorityResolver.sv
src/channelRegisters.sv
src/timingAndControl.sv
src/dmaController.sv
verif/dmaControllerTb.sv

// File: run.sh
#!/bin/sh
# Compile the testbench and DUT with Verilator, then run; exit status is the result.
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -Wno-fatal --top-module dmaControllerTb \
    -f dmaController.f -o dmaSim &&
  ./obj_dir/dmaSim ||
  exit 1

// File: verif/dmaControllerTb.sv
`timescale 1ns/10ps
`include "dma_defines.svh"

module dmaControllerTb
  import dmaPkg::*;
();

  localparam int TIMEOUT_CYCLES = 3000;  // Well above the few hundred cycles all tests need.
  localparam int DACK_WAIT      = 16;    // Hold delay plus S0 and SI with margin.

  logic                     CLK;
  logic                     RESET;
  logic                     cpuWrite;
  logic [3:0]               cpuAddr;
  logic [7:0]               cpuData;
  logic [`DMA_CHANNELS-1:0] dreq;
  logic [`DMA_CHANNELS-1:0] dack;
  logic [`DMA_ADDR_W-1:0]   addr;
  logic                     hrq;
  logic                     hlda;
  logic                     aen;
  logic                     adstb;
  logic                     memrN;
  logic                     memwN;
  logic                     iorN;
  logic                     iowN;
  logic                     eopN;
  logic                     extEopN;

  int                       cycleCount = 0;
  int                       hldaRiseCycle = 0;
  logic                     holdOff = 1'b0;   // Host refuses the bus while set.
  logic [`DMA_ADDR_W-1:0]   nextAddr [`DMA_CHANNELS];
  logic                     downMode [`DMA_CHANNELS];

  dmaController dut (.*);

  initial
  begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  always @(posedge CLK)
  begin
    cycleCount = cycleCount + 1;
    if (cycleCount > TIMEOUT_CYCLES)
      abortRun("Timeout: the tests did not finish within the cycle limit.");
  end

  // Host side. Grants the bus 0 to 3 cycles after hrq.
  initial
  begin : holdAckModel
    int   delayLeft;
    logic armed;
    hlda      = 1'b0;
    armed     = 1'b0;
    delayLeft = 0;
    forever
    begin
      nextCycle();
      if (!hrq)
      begin
        hlda  = 1'b0;
        armed = 1'b0;
      end
      else if (!hlda)
      begin
        if (!armed)
        begin
          delayLeft = $urandom % 4;
          armed     = 1'b1;
        end
        if (delayLeft > 0)
          delayLeft--;
        else if (!holdOff)
        begin
          hlda          = 1'b1;
          hldaRiseCycle = cycleCount;
        end
      end
    end
  end

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    assert (actual === expected)
    else
      abortRun($sformatf("CHECK FAILED at %0t: %s expected %0h, actual %0h",
                         $time, name, expected, actual));
  endtask

  // Steps to the drive point just after the rising edge.
  task automatic nextCycle();
    @(posedge CLK);
    #2;
  endtask

  task automatic expectIdle(input int cycles);
    repeat (cycles)
    begin
      nextCycle();
      checkValue("{hrq,aen,dack}", 0, {hrq, aen, dack});
    end
  endtask

  task automatic writeReg(input logic [3:0] regAddr, input logic [7:0] data);
    cpuWrite = 1'b1;
    cpuAddr  = regAddr;
    cpuData  = data;
    nextCycle();
    cpuWrite = 1'b0;
  endtask

  task automatic programChannel(input int ch, input logic [15:0] base, input logic [15:0] count,
                                input transferTypeE ttype, input logic dec);
    writeReg(`REG_CLRFF, 8'h00);
    writeReg(4'(2 * ch), base[7:0]);       // Low byte first.
    writeReg(4'(2 * ch), base[15:8]);
    writeReg(4'(2 * ch + 1), count[7:0]);
    writeReg(4'(2 * ch + 1), count[15:8]);
    writeReg(`REG_MODE, {2'b00, dec, 1'b0, ttype, 2'(ch)});
    writeReg(`REG_MASK, {6'b0, 2'(ch)});   // Bit 2 low clears the mask.
    nextAddr[ch] = base;
    downMode[ch] = dec;
  endtask

  // Returns at the first dack cycle (S1).
  task automatic waitForDack(input int ch);
    int waited;
    waited = 0;
    while (dack == '0)
    begin
      if (waited == DACK_WAIT)
        abortRun($sformatf("Channel %0d got no dack within %0d cycles.", ch, DACK_WAIT));
      nextCycle();
      waited++;
    end
    checkValue("cycle of first dack", hldaRiseCycle + 1, cycleCount);
  endtask

  task automatic runTransfer(input int ch, input transferTypeE ttype, input logic lastOne);
    logic strobe;
    logic wr;
    logic rd;
    wr = (ttype == xferWrite);
    rd = (ttype == xferRead);
    waitForDack(ch);
    for (int cyc = 1; cyc <= 4; cyc++)
    begin
      strobe = (cyc == 2) || (cyc == 3);
      checkValue("dack", 1 << ch, dack);
      checkValue("{hrq,aen}", 2'b11, {hrq, aen});
      checkValue("adstb", cyc == 1, adstb);
      checkValue("addr", nextAddr[ch], addr);
      checkValue("{memrN,memwN,iorN,iowN}",
                 {!(strobe && rd), !(strobe && wr), !(strobe && wr), !(strobe && rd)},
                 {memrN, memwN, iorN, iowN});
      checkValue("eopN", !(cyc == 4 && lastOne), eopN);
      nextCycle();
    end
    checkValue("{hrq,aen,dack}", 0, {hrq, aen, dack});   // Back in SI.
    nextAddr[ch] = downMode[ch] ? nextAddr[ch] - 1'b1 : nextAddr[ch] + 1'b1;
  endtask

  task automatic testReset();
    checkValue("{hrq,aen,adstb,dack}", 0, {hrq, aen, adstb, dack});
    checkValue("{memrN,memwN,iorN,iowN,eopN}", 5'h1f, {memrN, memwN, iorN, iowN, eopN});
    dreq = '1;
    expectIdle(6);
    dreq = '0;
  endtask

  task automatic testTransferTypes();
    transferTypeE types [3];
    int           ch;
    types = '{xferWrite, xferRead, xferVerify};
    foreach (types[i])
    begin
      ch = $urandom % `DMA_CHANNELS;
      programChannel(ch, 16'($urandom), 16'h0000, types[i], 1'b0);
      dreq[ch] = 1'b1;
      checkValue("hrq", 0, hrq);
      nextCycle();
      checkValue("hrq", 1, hrq);
      runTransfer(ch, types[i], 1'b1);   // Count zero ends at once.
      dreq = '0;
      expectIdle(2);
    end
  endtask

  task automatic testCounting(input logic dec);
    int ch;
    int count;
    ch    = $urandom % `DMA_CHANNELS;
    count = 1 + $urandom % 4;
    programChannel(ch, 16'($urandom), 16'(count), xferWrite, dec);
    dreq[ch] = 1'b1;
    for (int n = 0; n <= count; n++)
      runTransfer(ch, xferWrite, n == count);
    expectIdle(8);   // Masked by terminal count.
    dreq = '0;
  endtask

  task automatic testPriority();
    for (int ch = 0; ch < `DMA_CHANNELS; ch++)
      programChannel(ch, 16'($urandom), 16'h00ff, xferRead, 1'b0);
    dreq = '1;
    repeat (3)
      runTransfer(0, xferRead, 1'b0);
    dreq = '0;
    expectIdle(1);
    writeReg(`REG_CMD, 8'h10);
    dreq = '1;
    for (int n = 0; n < 5; n++)
      runTransfer(n % `DMA_CHANNELS, xferRead, 1'b0);
    dreq = '0;
    expectIdle(1);
  endtask

  task automatic testAbort();
    int ch;
    ch = $urandom % `DMA_CHANNELS;
    programChannel(ch, 16'($urandom), 16'h0005, xferWrite, 1'b0);
    dreq[ch] = 1'b1;
    waitForDack(ch);
    nextCycle();
    checkValue("{iorN,memwN}", 2'b00, {iorN, memwN});   // In S2.
    extEopN = 1'b0;
    nextCycle();
    extEopN = 1'b1;
    expectIdle(6);
    writeReg(`REG_MASK, {6'b0, 2'(ch)});
    runTransfer(ch, xferWrite, 1'b0);   // Address was not stepped.
    dreq = '0;
    expectIdle(1);
  endtask

  task automatic testBackPressureAndClear();
    int ch;
    ch = $urandom % `DMA_CHANNELS;
    programChannel(ch, 16'($urandom), 16'h0003, xferVerify, 1'b0);
    holdOff  = 1'b1;
    dreq[ch] = 1'b1;
    repeat (8)
    begin
      nextCycle();
      checkValue("hrq", 1, hrq);
      checkValue("{aen,dack}", 0, {aen, dack});
    end
    writeReg(`REG_MCLR, 8'h00);
    nextCycle();
    checkValue("hrq", 0, hrq);
    holdOff = 1'b0;
    dreq    = '1;
    expectIdle(8);   // Master clear set every mask.
    dreq    = '0;
  endtask

  initial
  begin
    void'($urandom(32'hdcde2816));
    RESET    = 1'b1;
    cpuWrite = 1'b0;
    cpuAddr  = '0;
    cpuData  = '0;
    dreq     = '0;
    extEopN  = 1'b1;
    repeat (3) @(posedge CLK);
    #2;
    RESET = 1'b0;
    testReset();
    testTransferTypes();
    testCounting(1'b0);
    testCounting(1'b1);
    testPriority();
    testAbort();
    testBackPressureAndClear();
    $display("Verification passed");
    $finish;
  end

endmodule

// File: src/dmaController.sv
`timescale 1ns/10ps
`include "dma_defines.svh"

module dmaController
  import dmaPkg::*;
(
  input  logic                     CLK,
  input  logic                     RESET,
  input  logic                     cpuWrite,
  input  logic [3:0]               cpuAddr,
  input  logic [7:0]               cpuData,
  input  logic [`DMA_CHANNELS-1:0] dreq,
  output logic [`DMA_CHANNELS-1:0] dack,
  output logic                     hrq,
  input  logic                     hlda,
  output logic                     aen,
  output logic                     adstb,
  output logic [`DMA_ADDR_W-1:0]   addr,
  output logic                     memrN,
  output logic                     memwN,
  output logic                     iorN,
  output logic                     iowN,
  output logic                     eopN,
  input  logic                     extEopN
);

  logic                     pending;
  logic [`DMA_CH_W-1:0]     winner;
  logic [`DMA_CHANNELS-1:0] mask;
  logic                     rotate;
  modeRegT                  selMode;
  logic                     selCountZero;
  logic [`DMA_CH_W-1:0]     svcChannel;
  logic                     advance;
  logic                     maskSet;
  logic                     served;
  logic                     regWrite;

  assign regWrite = cpuWrite & ~aen;   // CPU is locked out while the DMA owns the bus.

  priorityResolver resolver (
    .CLK(CLK), .RESET(RESET), .dreq(dreq), .mask(mask), .rotate(rotate),
    .served(served), .svcChannel(svcChannel), .pending(pending), .winner(winner)
  );

  channelRegisters regs (
    .CLK(CLK), .RESET(RESET), .cpuWrite(regWrite), .cpuAddr(cpuAddr),
    .cpuData(cpuData), .svcChannel(svcChannel), .advance(advance),
    .maskSet(maskSet), .mask(mask), .rotate(rotate), .selMode(selMode),
    .selCountZero(selCountZero), .addr(addr)
  );

  timingAndControl control (
    .CLK(CLK), .RESET(RESET), .pending(pending), .winner(winner), .hlda(hlda),
    .extEopN(extEopN), .selMode(selMode), .selCountZero(selCountZero),
    .hrq(hrq), .dack(dack), .aen(aen), .adstb(adstb), .memrN(memrN),
    .memwN(memwN), .iorN(iorN), .iowN(iowN), .eopN(eopN),
    .svcChannel(svcChannel), .advance(advance), .maskSet(maskSet), .served(served)
  );

endmodule

// File: src/timingAndControl.sv
`timescale 1ns/10ps
`include "dma_defines.svh"

module timingAndControl
  import dmaPkg::*;
(
  input  logic                     CLK,
  input  logic                     RESET,
  input  logic                     pending,
  input  logic [`DMA_CH_W-1:0]     winner,
  input  logic                     hlda,
  input  logic                     extEopN,
  input  modeRegT                  selMode,
  input  logic                     selCountZero,
  output logic                     hrq,
  output logic [`DMA_CHANNELS-1:0] dack,
  output logic                     aen,
  output logic                     adstb,
  output logic                     memrN,
  output logic                     memwN,
  output logic                     iorN,
  output logic                     iowN,
  output logic                     eopN,
  output logic [`DMA_CH_W-1:0]     svcChannel,
  output logic                     advance,
  output logic                     maskSet,
  output logic                     served
);

  dmaStateE state;
  dmaStateE nextState;
  logic     busOwned;      // S1 through S4.
  logic     strobeTime;    // S2 and S3.
  logic     termCount;
  logic     abort;

  always_ff @(posedge CLK)
  begin
    if (RESET)
      state <= SI;
    else
      state <= nextState;
  end

  always_comb
  begin
    nextState = state;
    unique case (1'b1)
      state[siIdx]:
        if (pending)
          nextState = S0;
      state[s0Idx]:
        if (!pending)
          nextState = SI;
        else if (hlda)
          nextState = S1;   // Otherwise wait here with hrq high.
      state[s1Idx]:
        nextState = extEopN ? S2 : SI;
      state[s2Idx]:
        nextState = extEopN ? S3 : SI;
      state[s3Idx]:
        nextState = extEopN ? S4 : SI;
      state[s4Idx]:
        nextState = SI;
      default:
        nextState = SI;
    endcase
  end

  // Channel is frozen for the whole transfer.
  always_ff @(posedge CLK)
  begin
    if (RESET)
      svcChannel <= '0;
    else if (state[s0Idx] && pending && hlda)
      svcChannel <= winner;
  end

  assign busOwned   = state[s1Idx] | state[s2Idx] | state[s3Idx] | state[s4Idx];
  assign strobeTime = state[s2Idx] | state[s3Idx];

  assign hrq   = ~state[siIdx];
  assign aen   = busOwned;
  assign adstb = state[s1Idx];
  assign dack  = busOwned ? (`DMA_CHANNELS'(1) << svcChannel) : '0;

  // Verify drives no strobe at all.
  assign iorN  = ~(strobeTime && selMode.transferType == xferWrite);
  assign memwN = ~(strobeTime && selMode.transferType == xferWrite);
  assign memrN = ~(strobeTime && selMode.transferType == xferRead);
  assign iowN  = ~(strobeTime && selMode.transferType == xferRead);

  assign abort     = busOwned && !extEopN;
  assign advance   = state[s4Idx] && extEopN;
  assign termCount = advance && selCountZero;   // Count was zero before this step.
  assign eopN      = ~termCount;
  assign maskSet   = termCount || abort;
  assign served    = advance;

  stateOneHot: assert property (
    @(posedge CLK) disable iff (RESET)
    $onehot(state)
  );

  singleDack: assert property (
    @(posedge CLK) disable iff (RESET)
    aen |-> $onehot(dack)
  );

endmodule

// File: src/channelRegisters.sv
`timescale 1ns/10ps
`include "dma_defines.svh"

module channelRegisters
  import dmaPkg::*;
(
  input  logic                     CLK,
  input  logic                     RESET,
  input  logic                     cpuWrite,
  input  logic [3:0]               cpuAddr,
  input  logic [7:0]               cpuData,
  input  logic [`DMA_CH_W-1:0]     svcChannel,
  input  logic                     advance,
  input  logic                     maskSet,
  output logic [`DMA_CHANNELS-1:0] mask,
  output logic                     rotate,
  output modeRegT                  selMode,
  output logic                     selCountZero,
  output logic [`DMA_ADDR_W-1:0]   addr
);

  logic [`DMA_ADDR_W-1:0] curAddr [`DMA_CHANNELS];
  logic [`DMA_ADDR_W-1:0] curCount [`DMA_CHANNELS];
  modeRegT                modeReg [`DMA_CHANNELS];
  logic                   bytePtr;      // High byte is next when set.
  logic [`DMA_CH_W-1:0]   wrChannel;
  logic                   chanWrite;
  logic                   masterClear;

  assign wrChannel   = cpuAddr[2:1];
  assign chanWrite   = cpuWrite && !cpuAddr[3];   // Offsets 0 to 7.
  assign masterClear = cpuWrite && (cpuAddr == `REG_MCLR);

  always_ff @(posedge CLK)
  begin
    if (RESET)
      bytePtr <= 1'b0;
    else if (masterClear || (cpuWrite && cpuAddr == `REG_CLRFF))
      bytePtr <= 1'b0;
    else if (chanWrite)
      bytePtr <= ~bytePtr;
  end

  // Current address and count load one byte per write.
  always_ff @(posedge CLK)
  begin
    if (RESET)
    begin
      for (int i = 0; i < `DMA_CHANNELS; i++)
      begin
        curAddr[i]  <= '0;
        curCount[i] <= '0;
      end
    end
    else if (chanWrite)
    begin
      if (cpuAddr[0])
      begin
        if (bytePtr)
          curCount[wrChannel][`DMA_ADDR_W-1:8] <= cpuData;
        else
          curCount[wrChannel][7:0] <= cpuData;
      end
      else
      begin
        if (bytePtr)
          curAddr[wrChannel][`DMA_ADDR_W-1:8] <= cpuData;
        else
          curAddr[wrChannel][7:0] <= cpuData;
      end
    end
    else if (advance)
    begin
      if (selMode.decrement)
        curAddr[svcChannel] <= curAddr[svcChannel] - 1'b1;
      else
        curAddr[svcChannel] <= curAddr[svcChannel] + 1'b1;
      curCount[svcChannel] <= curCount[svcChannel] - 1'b1;
    end
  end

  // Mode, mask and command registers.
  always_ff @(posedge CLK)
  begin
    if (RESET || masterClear)
    begin
      mask   <= '1;    // Every channel starts masked.
      rotate <= 1'b0;
      for (int i = 0; i < `DMA_CHANNELS; i++)
        modeReg[i] <= '0;
    end
    else
    begin
      if (cpuWrite)
      begin
        case (cpuAddr)
          `REG_CMD:
            rotate <= cpuData[`CMD_ROTATE_BIT];
          `REG_MASK:
            mask[cpuData[`DMA_CH_W-1:0]] <= cpuData[`MASK_SET_BIT];
          `REG_MODE:
          begin
            modeReg[cpuData[`DMA_CH_W-1:0]].transferType <=
              transferTypeE'(cpuData[`MODE_TYPE_HI:`MODE_TYPE_LO]);
            modeReg[cpuData[`DMA_CH_W-1:0]].decrement <= cpuData[`MODE_DEC_BIT];
          end
          default:
            rotate <= rotate;
        endcase
      end
      if (maskSet)
        mask[svcChannel] <= 1'b1;   // Terminal count or abort.
    end
  end

  assign selMode      = modeReg[svcChannel];
  assign selCountZero = (curCount[svcChannel] == '0);
  assign addr         = curAddr[svcChannel];

  // CPU writes are blocked at the top while the bus is owned.
  noWriteDuringAdvance: assert property (
    @(posedge CLK) disable iff (RESET)
    !(advance && cpuWrite)
  );

endmodule

// File: src/priorityResolver.sv
`timescale 1ns/10ps
`include "dma_defines.svh"

module priorityResolver
(
  input  logic                     CLK,
  input  logic                     RESET,
  input  logic [`DMA_CHANNELS-1:0] dreq,
  input  logic [`DMA_CHANNELS-1:0] mask,
  input  logic                     rotate,
  input  logic                     served,
  input  logic [`DMA_CH_W-1:0]     svcChannel,
  output logic                     pending,
  output logic [`DMA_CH_W-1:0]     winner
);

  logic [`DMA_CH_W-1:0]     topChannel;  // One past the last served channel.
  logic [`DMA_CHANNELS-1:0] active;
  logic [`DMA_CH_W-1:0]     base;
  logic [`DMA_CH_W-1:0]     idx;
  logic                     found;

  assign active  = dreq & ~mask;
  assign pending = |active;
  assign base    = rotate ? topChannel : '0;   // Fixed priority starts at channel 0.

  // The pointer only moves while rotation is enabled.
  always_ff @(posedge CLK)
  begin
    if (RESET)
      topChannel <= '0;
    else if (served && rotate)
      topChannel <= svcChannel + 1'b1;
  end

  // Scan from the highest priority channel upward, wrapping around.
  always_comb
  begin
    winner = base;
    found  = 1'b0;
    idx    = base;
    for (int i = 0; i < `DMA_CHANNELS; i++)
    begin
      idx = base + `DMA_CH_W'(i);
      if (!found && active[idx])
      begin
        winner = idx;
        found  = 1'b1;
      end
    end
  end

  winnerIsRequesting: assert property (
    @(posedge CLK) disable iff (RESET)
    pending |-> (dreq[winner] && !mask[winner])
  );

endmodule

// File: src/dmaPkg.sv
package dmaPkg;

  typedef enum logic [1:0] {
    xferVerify = 2'd0,
    xferWrite  = 2'd1,  // I/O read to memory write.
    xferRead   = 2'd2   // Memory read to I/O write.
  } transferTypeE;

  // Bit positions of the one-hot state vector.
  typedef enum int {
    siIdx = 0,
    s0Idx = 1,
    s1Idx = 2,
    s2Idx = 3,
    s3Idx = 4,
    s4Idx = 5
  } dmaStateIdxE;

  typedef enum logic [5:0] {
    SI = 6'b000001 << siIdx,
    S0 = 6'b000001 << s0Idx,
    S1 = 6'b000001 << s1Idx,
    S2 = 6'b000001 << s2Idx,
    S3 = 6'b000001 << s3Idx,
    S4 = 6'b000001 << s4Idx
  } dmaStateE;

  typedef struct packed {
    transferTypeE transferType;
    logic         decrement;    // Address steps down when set.
  } modeRegT;

endpackage

// File: src/dma_defines.svh
`ifndef DMA_DEFINES_SVH
`define DMA_DEFINES_SVH

`define DMA_CHANNELS 4
`define DMA_CH_W     2
`define DMA_ADDR_W   16

// CPU register map on the 4-bit address.
// Channel n address sits at 2n, its count at 2n+1.
`define REG_CMD   4'd8
`define REG_MASK  4'd10
`define REG_MODE  4'd11
`define REG_CLRFF 4'd12
`define REG_MCLR  4'd13

`define CMD_ROTATE_BIT 4
`define MASK_SET_BIT   2
`define MODE_DEC_BIT   5
`define MODE_TYPE_HI   3
`define MODE_TYPE_LO   2

`endif
